// ==== pdp_pool_macros.svh ====
// size macros: element width, word lanes, kernel limit, line-buffer depth, reciprocal shift
`ifndef PDP_POOL_MACROS_SVH
`define PDP_POOL_MACROS_SVH

// ====================
// data path sizes
// ====================
`define PDP_ELEM_W      8   // int8 feature element
`define PDP_LANES       4   // elements per input word

// ====================
// kernel and buffers
// ====================
`define PDP_KERN_MAX    4   // largest kernel side
`define PDP_LINE_DEPTH  64  // partials per row, max output width

// average scaling
`define PDP_RECIP_SHIFT 16  // fraction bits of the reciprocal

`endif

// ==== pdp_pool_pkg.sv ====
// shared vector types, pooling enums and the window combine function
`include "pdp_pool_macros.svh"

package pdp_pool_pkg;

  typedef logic signed [`PDP_ELEM_W-1:0] elem_t;                       // one feature element
  typedef logic [`PDP_ELEM_W*`PDP_LANES-1:0] word_t;                   // packed input word
  typedef logic signed [`PDP_ELEM_W+$clog2(`PDP_KERN_MAX*`PDP_KERN_MAX)-1:0] sum_t;
  typedef logic [$clog2(`PDP_KERN_MAX+1)-1:0] kern_t;                  // kernel side 1..4
  typedef logic [7:0] width_t;                                         // column or row count
  typedef logic [`PDP_RECIP_SHIFT-1:0] recip_t;                        // 0.16 unsigned

  typedef enum logic [1:0] {
    POOL_AVG = 2'd0,
    POOL_MAX = 2'd1,
    POOL_MIN = 2'd2
  } pool_type_e;

  typedef enum logic {
    OP_IDLE = 1'b0,
    OP_BUSY = 1'b1
  } op_state_e;

  // merges a new value into a running window value
  function automatic sum_t pool_combine(pool_type_e pt, sum_t acc, sum_t val);
    sum_t res;
    case (pt)
      POOL_MAX: res = (val > acc) ? val : acc;
      POOL_MIN: res = (val < acc) ? val : acc;
      default:  res = acc + val; // avg accumulates
    endcase
    return res;
  endfunction

endpackage

// ==== pdp_pool_preproc.sv ====
// preproc stage: holds one input word and emits its lanes one element at a time
`timescale 1ns/1ps
`include "pdp_pool_macros.svh"

module pdp_pool_preproc (
  input  logic                  nvdla_core_clk,
  input  logic                  nvdla_core_rstn,
  input  logic                  sdp_valid,
  input  pdp_pool_pkg::word_t   sdp_pd,
  output logic                  sdp_ready,
  output logic                  pre_valid,
  output pdp_pool_pkg::elem_t   pre_pd,
  input  logic                  pre_ready
);
  import pdp_pool_pkg::*;

  localparam int LANE_W = $clog2(`PDP_LANES);

  word_t             word_q;  // held input word
  logic              full_q;  // word holder occupied
  logic [LANE_W-1:0] lane_q;  // next lane to emit
  logic              sdp_fire;
  logic              pre_fire;
  logic              last_lane;

  assign last_lane = (lane_q == LANE_W'(`PDP_LANES - 1));
  assign pre_fire  = pre_valid && pre_ready;
  // free holder, or holder drains this cycle
  assign sdp_ready = !full_q || (pre_fire && last_lane);
  assign sdp_fire  = sdp_valid && sdp_ready;

  assign pre_valid = full_q;
  assign pre_pd    = elem_t'(word_q[lane_q*`PDP_ELEM_W +: `PDP_ELEM_W]); // lane 0 lowest

  // ====================
  // holder control
  // ====================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      full_q <= 1'b0;
      lane_q <= '0;
    end else if (sdp_fire) begin
      full_q <= 1'b1;
      lane_q <= '0;  // restart at lane 0
    end else if (pre_fire) begin
      lane_q <= lane_q + 1'b1;
      if (last_lane) begin
        full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (sdp_fire) begin
      word_q <= sdp_pd;
    end
  end

endmodule

// ==== pdp_pool_cal1d.sv ====
// cal1d stage: op start detection, config capture and horizontal window reduction
`timescale 1ns/1ps

module pdp_pool_cal1d (
  input  logic                      nvdla_core_clk,
  input  logic                      nvdla_core_rstn,
  input  logic                      op_en,
  input  pdp_pool_pkg::pool_type_e  pooling_type,
  input  pdp_pool_pkg::kern_t       kernel_width,
  input  logic                      pre_valid,
  input  pdp_pool_pkg::elem_t       pre_pd,
  output logic                      pre_ready,
  output logic                      op_start,
  output logic                      p1d_valid,
  output pdp_pool_pkg::sum_t        p1d_pd,
  input  logic                      p1d_ready
);
  import pdp_pool_pkg::*;

  op_state_e  state_q;
  logic       op_start_q;
  pool_type_e type_q;     // captured at op start
  kern_t      kw_q;
  kern_t      cnt_q;      // position inside the group
  sum_t       acc_q;      // running group value
  sum_t       elem_ext;
  sum_t       comb;
  logic       last_elem;
  logic       pre_fire;
  logic       p1d_valid_q;
  sum_t       p1d_pd_q;

  // ====================
  // op start
  // ====================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      state_q    <= OP_IDLE;
      op_start_q <= 1'b0;
    end else begin
      op_start_q <= (state_q == OP_IDLE) && op_en;  // rising edge of op_en
      state_q    <= op_en ? OP_BUSY : OP_IDLE;
    end
  end

  assign op_start = op_start_q;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      type_q <= POOL_AVG;
      kw_q   <= kern_t'(1);
    end else if (op_start_q) begin
      type_q <= pooling_type;
      kw_q   <= kernel_width;
    end
  end

  // ====================
  // horizontal reduction
  // ====================
  assign pre_ready = !p1d_valid_q || p1d_ready;  // stall only on a waiting partial
  assign pre_fire  = pre_valid && pre_ready;
  assign elem_ext  = sum_t'(pre_pd);              // sign extend
  assign last_elem = (cnt_q == kern_t'(kw_q - 3'd1));
  assign comb      = (cnt_q == '0) ? elem_ext : pool_combine(type_q, acc_q, elem_ext);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cnt_q <= '0;
    end else if (op_start_q) begin
      cnt_q <= '0;
    end else if (pre_fire) begin
      cnt_q <= last_elem ? '0 : cnt_q + 1'b1;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (pre_fire && !last_elem) begin
      acc_q <= comb;
    end
  end

  // one-entry output register
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      p1d_valid_q <= 1'b0;
    end else if (pre_fire && last_elem) begin
      p1d_valid_q <= 1'b1;
    end else if (p1d_ready) begin
      p1d_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (pre_fire && last_elem) begin
      p1d_pd_q <= comb;
    end
  end

  assign p1d_valid = p1d_valid_q;
  assign p1d_pd    = p1d_pd_q;

endmodule

// ==== pdp_pool_cal2d.sv ====
// cal2d stage: line buffer, vertical reduction, average scaling and output register
`timescale 1ns/1ps
`include "pdp_pool_macros.svh"

module pdp_pool_cal2d (
  input  logic                      nvdla_core_clk,
  input  logic                      nvdla_core_rstn,
  input  logic                      op_start,
  input  pdp_pool_pkg::pool_type_e  pooling_type,
  input  pdp_pool_pkg::kern_t       kernel_height,
  input  pdp_pool_pkg::width_t      cube_out_width,
  input  pdp_pool_pkg::recip_t      recip,
  input  logic                      p1d_valid,
  input  pdp_pool_pkg::sum_t        p1d_pd,
  output logic                      p1d_ready,
  output logic                      out_valid,
  output pdp_pool_pkg::elem_t       out_pd,
  input  logic                      out_ready
);
  import pdp_pool_pkg::*;

  localparam int LINE_AW = $clog2(`PDP_LINE_DEPTH);
  localparam int SUM_W   = $bits(sum_t);
  localparam int PROD_W  = SUM_W + `PDP_RECIP_SHIFT + 1;

  pool_type_e type_q;
  kern_t      kh_q;
  width_t     ow_q;
  recip_t     recip_q;

  width_t     col_q;      // output column
  kern_t      row_q;      // row inside the band
  sum_t       line_mem [`PDP_LINE_DEPTH];
  sum_t       stored;
  sum_t       comb;
  logic       first_row;
  logic       last_row;
  logic       last_col;
  logic       p1d_fire;

  logic signed [PROD_W-1:0] prod;
  logic signed [PROD_W-1:0] scaled;
  elem_t      result;
  logic       out_valid_q;
  elem_t      out_pd_q;

  // ====================
  // config capture
  // ====================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      type_q  <= POOL_AVG;
      kh_q    <= kern_t'(1);
      ow_q    <= width_t'(1);
      recip_q <= '0;
    end else if (op_start) begin
      type_q  <= pooling_type;
      kh_q    <= kernel_height;
      ow_q    <= cube_out_width;
      recip_q <= recip;
    end
  end

  // ====================
  // vertical reduction
  // ====================
  assign first_row = (row_q == '0);
  assign last_row  = (row_q == kern_t'(kh_q - 3'd1));
  assign last_col  = (col_q == width_t'(ow_q - 8'd1));

  // only the last row of a band needs the output slot
  assign p1d_ready = !last_row || !out_valid_q || out_ready;
  assign p1d_fire  = p1d_valid && p1d_ready;

  assign stored = line_mem[col_q[LINE_AW-1:0]];
  assign comb   = first_row ? p1d_pd : pool_combine(type_q, stored, p1d_pd);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      col_q <= '0;
      row_q <= '0;
    end else if (op_start) begin
      col_q <= '0;
      row_q <= '0;
    end else if (p1d_fire) begin
      if (last_col) begin
        col_q <= '0;
        row_q <= last_row ? '0 : row_q + 1'b1;  // next row of the band
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (p1d_fire && !last_row) begin
      line_mem[col_q[LINE_AW-1:0]] <= comb;
    end
  end

  // ====================
  // scaling and output
  // ====================
  assign prod   = comb * $signed({1'b0, recip_q});  // recip is unsigned
  assign scaled = prod >>> `PDP_RECIP_SHIFT;
  assign result = (type_q == POOL_AVG) ? elem_t'(scaled[`PDP_ELEM_W-1:0])
                                       : elem_t'(comb[`PDP_ELEM_W-1:0]);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      out_valid_q <= 1'b0;
    end else if (p1d_fire && last_row) begin
      out_valid_q <= 1'b1;
    end else if (out_ready) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (p1d_fire && last_row) begin
      out_pd_q <= result;
    end
  end

  assign out_valid = out_valid_q;
  assign out_pd    = out_pd_q;

endmodule

// ==== pdp_pool_core.sv ====
// pooling engine top: preproc, horizontal and vertical stages
`timescale 1ns/1ps

module pdp_pool_core (
  input  logic                      nvdla_core_clk,
  input  logic                      nvdla_core_rstn,
  input  logic                      op_en,
  input  pdp_pool_pkg::pool_type_e  pooling_type,
  input  pdp_pool_pkg::kern_t       kernel_width,
  input  pdp_pool_pkg::kern_t       kernel_height,
  input  pdp_pool_pkg::width_t      cube_out_width,
  input  pdp_pool_pkg::recip_t      recip,
  input  logic                      sdp_valid,
  input  pdp_pool_pkg::word_t       sdp_pd,
  output logic                      sdp_ready,
  output logic                      out_valid,
  output pdp_pool_pkg::elem_t       out_pd,
  input  logic                      out_ready
);
  import pdp_pool_pkg::*;

  logic  pre_valid;   // unpacked elements
  logic  pre_ready;
  elem_t pre_pd;
  logic  p1d_valid;   // horizontal partials
  logic  p1d_ready;
  sum_t  p1d_pd;
  logic  op_start;

  // ====================
  // stage chain
  // ====================
  pdp_pool_preproc u_preproc (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .sdp_valid       (sdp_valid),
    .sdp_pd          (sdp_pd),
    .sdp_ready       (sdp_ready),
    .pre_valid       (pre_valid),
    .pre_pd          (pre_pd),
    .pre_ready       (pre_ready)
  );

  pdp_pool_cal1d u_cal1d (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_en           (op_en),
    .pooling_type    (pooling_type),
    .kernel_width    (kernel_width),
    .pre_valid       (pre_valid),
    .pre_pd          (pre_pd),
    .pre_ready       (pre_ready),
    .op_start        (op_start),
    .p1d_valid       (p1d_valid),
    .p1d_pd          (p1d_pd),
    .p1d_ready       (p1d_ready)
  );

  pdp_pool_cal2d u_cal2d (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_start        (op_start),        // config sample point
    .pooling_type    (pooling_type),
    .kernel_height   (kernel_height),
    .cube_out_width  (cube_out_width),
    .recip           (recip),
    .p1d_valid       (p1d_valid),
    .p1d_pd          (p1d_pd),
    .p1d_ready       (p1d_ready),
    .out_valid       (out_valid),
    .out_pd          (out_pd),
    .out_ready       (out_ready)
  );

endmodule

// ==== pdp_pool_props.sv ====
// handshake properties: input hold, output hold, quiet output before the first op start
`timescale 1ns/1ps

module pdp_pool_props (
  input logic                 nvdla_core_clk,
  input logic                 nvdla_core_rstn,
  input logic                 op_start,
  input logic                 sdp_valid,
  input pdp_pool_pkg::word_t  sdp_pd,
  input logic                 sdp_ready,
  input logic                 out_valid,
  input pdp_pool_pkg::elem_t  out_pd,
  input logic                 out_ready
);

  logic started_q;  // first op_start seen

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      started_q <= 1'b0;
    end else if (op_start) begin
      started_q <= 1'b1;
    end
  end

  sdp_hold: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    sdp_valid && !sdp_ready |=> sdp_valid && $stable(sdp_pd))
    else $error("input word withdrawn or changed while stalled");

  out_hold: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    out_valid && !out_ready |=> out_valid && $stable(out_pd))
    else $error("result withdrawn or changed while stalled");

  out_quiet: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !started_q |-> !out_valid)
    else $error("out_valid raised before the first op start");

endmodule

// ==== pdp_pool_tb.sv ====
// testbench: clock, reset, case table, golden model, driver, monitor, watchdog
`timescale 1ns/1ps
`include "pdp_pool_macros.svh"

module pdp_pool_tb;
  import pdp_pool_pkg::*;

  typedef struct packed {
    pool_type_e pt;
    kern_t      kw;
    kern_t      kh;
    width_t     w;        // input width
    width_t     h;        // input height
    recip_t     recip;
    logic [7:0] in_gap;   // percent idle input cycles
    logic [7:0] out_gap;  // percent cycles with out_ready low
  } case_t;

  localparam int NUM_CASES = 7;
  localparam int SEED      = 66771;
  localparam int MARGIN    = 500;

  // ====================
  // case table
  // ====================
  localparam case_t CASE_TBL [NUM_CASES] = '{
    '{POOL_MAX, 3'd2, 3'd2, 8'd8,  8'd4, 16'd0,     8'd20, 8'd20},  // 2x2 max
    '{POOL_MIN, 3'd4, 3'd1, 8'd16, 8'd2, 16'd0,     8'd20, 8'd20},  // row minima only
    '{POOL_AVG, 3'd2, 3'd2, 8'd8,  8'd4, 16'd16384, 8'd20, 8'd20},  // sum / 4
    '{POOL_MAX, 3'd1, 3'd1, 8'd8,  8'd2, 16'd0,     8'd10, 8'd10},  // pass through
    '{POOL_AVG, 3'd3, 3'd3, 8'd12, 8'd6, 16'd7282,  8'd70, 8'd70},  // heavy stalls
    '{POOL_MIN, 3'd2, 3'd4, 8'd8,  8'd4, 16'd0,     8'd30, 8'd30},
    '{POOL_AVG, 3'd4, 3'd4, 8'd16, 8'd4, 16'd4096,  8'd0,  8'd0}
  };

  logic       nvdla_core_clk = 1'b0;
  logic       nvdla_core_rstn;
  logic       op_en;
  pool_type_e pooling_type;
  kern_t      kernel_width;
  kern_t      kernel_height;
  width_t     cube_out_width;
  recip_t     recip;
  logic       sdp_valid;
  word_t      sdp_pd;
  logic       sdp_ready;
  logic       out_valid;
  elem_t      out_pd;
  logic       out_ready;

  int          data_q [$];   // elements in raster order
  word_t       words_q [$];
  int          exp_q [$];    // expected results in raster order
  logic [31:0] rng;
  logic [31:0] rng_in;
  logic [31:0] rng_out;

  always #10 nvdla_core_clk = ~nvdla_core_clk;

  pdp_pool_core dut_i (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_en           (op_en),
    .pooling_type    (pooling_type),
    .kernel_width    (kernel_width),
    .kernel_height   (kernel_height),
    .cube_out_width  (cube_out_width),
    .recip           (recip),
    .sdp_valid       (sdp_valid),
    .sdp_pd          (sdp_pd),
    .sdp_ready       (sdp_ready),
    .out_valid       (out_valid),
    .out_pd          (out_pd),
    .out_ready       (out_ready)
  );

  bind pdp_pool_core pdp_pool_props props_i (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_start        (op_start),
    .sdp_valid       (sdp_valid),
    .sdp_pd          (sdp_pd),
    .sdp_ready       (sdp_ready),
    .out_valid       (out_valid),
    .out_pd          (out_pd),
    .out_ready       (out_ready)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int table_elements();
    int k;
    int total;
    total = 0;
    for (k = 0; k < NUM_CASES; k++) begin
      total += int'(CASE_TBL[k].w) * int'(CASE_TBL[k].h);
    end
    return total;
  endfunction

  task automatic check_value(input logic signed [31:0] got, input logic signed [31:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
      $display("Finished with errors");
      $fatal(1, "result check failed");
    end
  endtask

  // ====================
  // golden model
  // ====================
  task automatic build_case(input case_t c);
    int    w, h, kw, kh;
    int    i, br, bc, dy, dx;
    int    acc, v;
    word_t wd;
    w  = int'(c.w);
    h  = int'(c.h);
    kw = int'(c.kw);
    kh = int'(c.kh);
    data_q.delete();
    words_q.delete();
    exp_q.delete();
    wd = '0;
    for (i = 0; i < w * h; i++) begin
      rng = xorshift(rng);
      v   = int'($signed(rng[7:0]));
      data_q.push_back(v);
      wd[(i % `PDP_LANES) * `PDP_ELEM_W +: `PDP_ELEM_W] = v[7:0];  // lane 0 first in the row
      if (i % `PDP_LANES == `PDP_LANES - 1) begin
        words_q.push_back(wd);
      end
    end
    for (br = 0; br < h / kh; br++) begin
      for (bc = 0; bc < w / kw; bc++) begin
        acc = 0;
        for (dy = 0; dy < kh; dy++) begin
          for (dx = 0; dx < kw; dx++) begin
            v = data_q[(br * kh + dy) * w + bc * kw + dx];
            if (dy == 0 && dx == 0) acc = v;
            else if (c.pt == POOL_MAX) acc = (v > acc) ? v : acc;
            else if (c.pt == POOL_MIN) acc = (v < acc) ? v : acc;
            else acc = acc + v;
          end
        end
        if (c.pt == POOL_AVG) begin
          acc = (acc * int'(c.recip)) >>> `PDP_RECIP_SHIFT;  // rounds toward minus infinity
        end
        exp_q.push_back(int'($signed(acc[7:0])));
      end
    end
  endtask

  // ====================
  // driver and monitor
  // ====================
  task automatic drive_words(input int gap);
    int   sent;
    logic busy;
    sent = 0;
    busy = 1'b0;
    while (sent < words_q.size()) begin
      @(posedge nvdla_core_clk);
      if (!busy) begin
        rng_in = xorshift(rng_in);
        if (rng_in % 100 >= gap) begin
          sdp_valid <= 1'b1;
          sdp_pd    <= words_q[sent];
          busy = 1'b1;
        end else begin
          sdp_valid <= 1'b0;  // idle gap
        end
      end
      @(negedge nvdla_core_clk);
      if (busy && sdp_ready) begin  // taken on the coming edge
        sent++;
        busy = 1'b0;
      end
    end
    @(posedge nvdla_core_clk);
    sdp_valid <= 1'b0;
  endtask

  task automatic collect_outputs(input int gap, input int idx);
    int got;
    got = 0;
    while (got < exp_q.size()) begin
      @(posedge nvdla_core_clk);
      rng_out = xorshift(rng_out);
      out_ready <= (rng_out % 100 >= gap);
      @(negedge nvdla_core_clk);
      if (out_valid && out_ready) begin
        check_value(out_pd, exp_q[got], $sformatf("case %0d result %0d", idx, got));
        got++;
      end
    end
  endtask

  task automatic run_case(input case_t c, input int idx);
    int k;
    build_case(c);
    @(posedge nvdla_core_clk);
    op_en          <= 1'b0;
    pooling_type   <= c.pt;
    kernel_width   <= c.kw;
    kernel_height  <= c.kh;
    cube_out_width <= width_t'(int'(c.w) / int'(c.kw));
    recip          <= c.recip;
    @(posedge nvdla_core_clk);
    op_en <= 1'b1;
    repeat (2) @(posedge nvdla_core_clk);  // op_start, then config capture
    fork
      drive_words(int'(c.in_gap));
      collect_outputs(int'(c.out_gap), idx);
    join
    for (k = 0; k < 8; k++) begin  // nothing beyond the expected count
      @(posedge nvdla_core_clk);
      out_ready <= 1'b1;
      @(negedge nvdla_core_clk);
      check_value(out_valid, 0, $sformatf("case %0d extra out_valid", idx));
    end
  endtask

  initial begin
    int ci;
    nvdla_core_rstn = 1'b0;
    op_en           = 1'b0;
    pooling_type    = POOL_AVG;
    kernel_width    = kern_t'(1);
    kernel_height   = kern_t'(1);
    cube_out_width  = width_t'(1);
    recip           = '0;
    sdp_valid       = 1'b0;
    sdp_pd          = '0;
    out_ready       = 1'b0;
    rng             = 32'(SEED);
    rng_in          = xorshift(rng ^ 32'h0000_5a5a);
    rng_out         = xorshift(rng ^ 32'h00a5_0000);
    repeat (8) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;
    repeat (2) @(posedge nvdla_core_clk);
    for (ci = 0; ci < NUM_CASES; ci++) begin
      run_case(CASE_TBL[ci], ci);
    end
    $display("Finished with no errors");
    $finish;
  end

  // ====================
  // watchdog
  // ====================
  initial begin
    int limit;
    limit = table_elements() * 40 + MARGIN;  // 40 cycles per input element
    repeat (limit) @(posedge nvdla_core_clk);
    $display("Timeout: the case table did not complete within %0d cycles", limit);
    $display("Finished with errors");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== pdp_pool.f ====
+incdir+.
pdp_pool_pkg.sv
pdp_pool_preproc.sv
pdp_pool_cal1d.sv
pdp_pool_cal2d.sv
pdp_pool_core.sv
pdp_pool_props.sv
pdp_pool_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the pooling testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  --top-module pdp_pool_tb -f pdp_pool.f -o pdp_pool_sim &&
./obj_dir/pdp_pool_sim 2>&1 | tee /dev/stderr | grep -x "Finished with no errors" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
